//--- tb.f
+incdir+.
exuPkg.sv
exuDecode.sv
exuExecute.sv
exuResult.sv
exuTop.sv
exu_props.sv
exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - .
    files:
      - exuPkg.sv
      - exuDecode.sv
      - exuExecute.sv
      - exuResult.sv
      - exuTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - exu_props.sv
      - exu_tb.sv

//--- exu_tb.sv
`default_nettype none
`include "exu_consts.svh"

module exu_tb import exuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        robResult_t rob;
        logic       wakeup; // rs and slb get it too
    } expect_t;

    logic       clk;
    logic       rst;
    logic       rdy;
    rsIssue_t   issue;
    cdbResult_t rsOut;
    cdbResult_t slbOut;
    robResult_t robOut;

    expect_t                expQ[$];
    int                     errors;
    int                     testErrBase;
    int                     testsDone;
    int                     issued;
    int                     received;
    bit                     toggling;
    logic [`EXU_NICK_W-1:0] nextNick;

    aluOp_e regOps[10] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                           OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    aluOp_e immOps[11] = '{OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                           OP_SLLI, OP_SRLI, OP_SRAI, OP_LUI, OP_AUIPC};
    aluOp_e brOps[6]   = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

    exuTop dut_i (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .issue  (issue),
        .rsOut  (rsOut),
        .slbOut (slbOut),
        .robOut (robOut)
    );

    always #2 clk = ~clk;

    function automatic logic isBranch(input aluOp_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    function automatic robResult_t refExec(input rsIssue_t ins);
        robResult_t              r;
        logic [`EXU_XLEN-1:0]    b;
        logic [`EXU_SHAMT_W-1:0] sh;
        r      = '0;
        r.en   = 1'b1;
        r.nick = ins.nick;
        b  = (ins.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                             OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND}) ? ins.rs2 : ins.imm;
        sh = b[`EXU_SHAMT_W-1:0];
        case (ins.op)
            OP_LUI:            r.data = ins.imm;
            OP_AUIPC:          r.data = ins.pc + ins.imm;
            OP_JAL, OP_JALR:   r.data = ins.pc + `EXU_LINK_STEP;
            OP_BEQ:            r.jump = ins.rs1 == ins.rs2;
            OP_BNE:            r.jump = ins.rs1 != ins.rs2;
            OP_BLT:            r.jump = $signed(ins.rs1) < $signed(ins.rs2);
            OP_BGE:            r.jump = $signed(ins.rs1) >= $signed(ins.rs2);
            OP_BLTU:           r.jump = ins.rs1 < ins.rs2;
            OP_BGEU:           r.jump = ins.rs1 >= ins.rs2;
            OP_ADD, OP_ADDI:   r.data = ins.rs1 + b;
            OP_SUB:            r.data = ins.rs1 - b;
            OP_SLL, OP_SLLI:   r.data = ins.rs1 << sh;
            OP_SLT, OP_SLTI:   r.data = {31'b0, $signed(ins.rs1) < $signed(b)};
            OP_SLTU, OP_SLTIU: r.data = {31'b0, ins.rs1 < b};
            OP_XOR, OP_XORI:   r.data = ins.rs1 ^ b;
            OP_SRL, OP_SRLI:   r.data = ins.rs1 >> sh;
            OP_SRA, OP_SRAI:   r.data = $signed(ins.rs1) >>> sh;
            OP_OR, OP_ORI:     r.data = ins.rs1 | b;
            default:           r.data = ins.rs1 & b; // AND, ANDI
        endcase
        if (ins.op == OP_JAL || ins.op == OP_JALR) begin
            r.jump = 1'b1;
        end
        if (ins.op == OP_JAL || isBranch(ins.op)) begin
            r.jumpPc = ins.pc + ins.imm;
        end
        if (ins.op == OP_JALR) begin
            r.jumpPc = (ins.rs1 + ins.imm) & ~32'd1;
        end
        if (!r.jump) begin
            r.jumpPc = '0;
        end
        return r;
    endfunction

    function automatic logic [`EXU_XLEN-1:0] edgeVal();
        case ($urandom % 6)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic rsIssue_t randIssue(input aluOp_e op);
        rsIssue_t    ins;
        logic [31:0] r;
        r        = $urandom;
        ins.en   = 1'b1;
        ins.op   = op;
        ins.nick = '0;
        ins.pc   = $urandom & 32'hffff_fffc;
        ins.rs1  = edgeVal();
        ins.rs2  = ($urandom % 4 == 0) ? ins.rs1 : edgeVal(); // equal operands now and then
        if (op inside {OP_LUI, OP_AUIPC}) begin
            ins.imm = r & 32'hffff_f000;
        end else if (op == OP_JAL || isBranch(op)) begin
            ins.imm = {{19{r[12]}}, r[12:1], 1'b0};
        end else begin
            ins.imm = {{20{r[11]}}, r[11:0]};
        end
        return ins;
    endfunction

    task automatic abortRun(input string msg);
        $display("timeout: %s", msg);
        $display("sim failed");
        $finish;
    endtask

    // returns at the advancing edge that took the issue
    task automatic sendIssue(input rsIssue_t ins);
        expect_t e;
        int      waited;
        waited = 0;
        @(negedge clk);
        ins.nick = nextNick;
        nextNick++;
        issue    = ins;
        e.rob    = refExec(ins);
        e.wakeup = !isBranch(ins.op);
        expQ.push_back(e);
        issued++;
        do begin
            @(posedge clk);
            waited++;
        end while (!rdy && waited < 100);
        if (!rdy) begin
            abortRun("an issue was not taken within 100 cycles");
        end
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        @(negedge clk);
        issue.en = 1'b0;
        while (expQ.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            abortRun("results still missing 200 cycles after the last issue");
        end
    endtask

    task automatic finishTest(input string name);
        testsDone++;
        $display("test %0d %s: %0d errors", testsDone, name, errors - testErrBase);
        testErrBase = errors;
    endtask

    // consumer side, one take per advancing edge
    always @(posedge clk) begin : monitor
        expect_t e;
        if (!rst && rdy) begin
            if (robOut.en) begin
                received++;
                if (expQ.size() == 0) begin
                    errors++;
                    $display("ERR %0t: ROB result nick %0d not expected", $time, robOut.nick);
                end else begin
                    e = expQ.pop_front();
                    if (robOut !== e.rob) begin
                        errors++;
                        $display("ERR %0t: ROB got %h, expected %h", $time, robOut, e.rob);
                    end
                    if (rsOut.en !== e.wakeup || slbOut.en !== e.wakeup) begin
                        errors++;
                        $display("ERR %0t: wakeup en rs %b slb %b, expected %b",
                                 $time, rsOut.en, slbOut.en, e.wakeup);
                    end else if (e.wakeup && (rsOut.nick !== e.rob.nick
                                 || rsOut.data !== e.rob.data || slbOut !== rsOut)) begin
                        errors++;
                        $display("ERR %0t: wakeup rs %h slb %h, expected nick %0d data %h",
                                 $time, rsOut, slbOut, e.rob.nick, e.rob.data);
                    end
                end
            end else if (rsOut.en || slbOut.en) begin
                errors++;
                $display("ERR %0t: wakeup without a ROB report", $time);
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(84296));
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        issue = '0;
        errors = 0;
        testErrBase = 0;
        testsDone = 0;
        issued = 0;
        received = 0;
        nextNick = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            if (rsOut.en || slbOut.en || robOut.en) begin
                errors++;
                $display("ERR %0t: output en high before any issue", $time);
            end
        end
        sendIssue(randIssue(OP_ADD));
        waited = 0;
        do begin
            @(negedge clk);
            issue.en = 1'b0;
            waited++;
        end while (!robOut.en && waited < 20);
        if (!robOut.en) begin
            abortRun("the first ADD never reached the ROB");
        end else if (waited != 3 || !rsOut.en || !slbOut.en) begin
            errors++;
            $display("ERR %0t: ADD on outputs after %0d cycles, expected 3", $time, waited);
        end
        drainPipe();
        finishTest("reset and latency");

        repeat (200) sendIssue(randIssue(regOps[$urandom % 10]));
        drainPipe();
        finishTest("register ALU ops");

        repeat (150) sendIssue(randIssue(immOps[$urandom % 11]));
        drainPipe();
        finishTest("immediate ops, LUI, AUIPC");

        repeat (150) sendIssue(randIssue(brOps[$urandom % 6]));
        drainPipe();
        finishTest("branches");

        repeat (60) sendIssue(randIssue(($urandom % 2) ? OP_JAL : OP_JALR));
        drainPipe();
        finishTest("JAL and JALR");

        toggling = 1'b1;
        fork
            begin
                repeat (300) sendIssue(randIssue(aluOp_e'($urandom % 29)));
                drainPipe();
                toggling = 1'b0;
            end
            while (toggling) begin
                @(negedge clk);
                rdy = ($urandom % 3) != 0;
            end
        join
        rdy = 1'b1;
        finishTest("random mix with rdy stalls");

        if (received != issued) begin
            errors++;
            $display("ERR %0t: %0d results for %0d issues", $time, received, issued);
        end
        if (dut_i.result_i.props_i.failures != 0) begin
            errors += dut_i.result_i.props_i.failures;
            $display("%0d assertion checks failed during the run",
                     dut_i.result_i.props_i.failures);
        end
        $display("tests %0d, issued %0d, received %0d, errors %0d",
                 testsDone, issued, received, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exu_props.sv
`default_nettype none

module exu_props import exuPkg::*; (
    input logic       clk,
    input logic       rst,
    input cdbResult_t rsOut,
    input cdbResult_t slbOut,
    input robResult_t robOut
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures; // read by the testbench at the end of the run

    enQuietAfterReset: assert property (@(posedge clk)
        rst |=> !(rsOut.en || slbOut.en || robOut.en))
        else begin
            failures++;
            $error("en output high in the cycle after reset");
        end

    wakeupPair: assert property (@(posedge clk) disable iff (rst)
        rsOut.en == slbOut.en)
        else begin
            failures++;
            $error("rs and slb wakeups differ");
        end

    // a wakeup always comes with its rob report
    wakeupHasRob: assert property (@(posedge clk) disable iff (rst)
        rsOut.en |-> robOut.en)
        else begin
            failures++;
            $error("wakeup without rob report");
        end

    noJumpNoTarget: assert property (@(posedge clk) disable iff (rst)
        !robOut.jump |-> robOut.jumpPc == '0)
        else begin
            failures++;
            $error("jump target set without a jump");
        end

endmodule

bind exuResult exu_props props_i (.*);

`default_nettype wire

//--- exuTop.sv
`default_nettype none

module exuTop import exuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rdy,
    input  rsIssue_t   issue,
    output cdbResult_t rsOut,
    output cdbResult_t slbOut,
    output robResult_t robOut
);

    decoded_t  dec;
    executed_t ex;

    exuDecode decode_i (
        .clk   (clk),
        .rst   (rst),
        .rdy   (rdy),
        .issue (issue),
        .dec   (dec)
    );

    exuExecute execute_i (
        .clk (clk),
        .rst (rst),
        .rdy (rdy),
        .dec (dec),
        .ex  (ex)
    );

    // three-stage latency ends here
    exuResult result_i (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .ex     (ex),
        .rsOut  (rsOut),
        .slbOut (slbOut),
        .robOut (robOut)
    );

endmodule

`default_nettype wire

//--- exuResult.sv
`default_nettype none

module exuResult import exuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rdy,
    input  executed_t  ex,
    output cdbResult_t rsOut,
    output cdbResult_t slbOut,
    output robResult_t robOut
);

    logic broadcast;
    logic [$bits(ex.data)-1:0] data;

    assign broadcast = ex.valid && ex.writesRd; // wakeup only when rd is written
    assign data      = ex.writesRd ? ex.data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsOut  <= '0;
            slbOut <= '0;
            robOut <= '0;
        end else if (rdy) begin
            rsOut.en    <= broadcast;
            rsOut.nick  <= ex.nick;
            rsOut.data  <= data;

            slbOut.en   <= broadcast;
            slbOut.nick <= ex.nick;
            slbOut.data <= data;

            // rob sees every instruction, branches included
            robOut.en     <= ex.valid;
            robOut.nick   <= ex.nick;
            robOut.data   <= data;
            robOut.jump   <= ex.jump;
            robOut.jumpPc <= ex.jumpPc;
        end
    end

endmodule

`default_nettype wire

//--- exuExecute.sv
`default_nettype none
`include "exu_consts.svh"

module exuExecute import exuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  decoded_t  dec,
    output executed_t ex
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic [`EXU_XLEN-1:0]    aluOut;
    logic                    taken;
    logic                    isJalr;
    logic [`EXU_ALEN-1:0]    target;

    assign shamt = dec.opB[`EXU_SHAMT_W-1:0]; // upper bits ignored

    always_comb begin
        case (dec.fn)
            FN_ADD:   aluOut = dec.opA + dec.opB;
            FN_SUB:   aluOut = dec.opA - dec.opB;
            FN_SLL:   aluOut = dec.opA << shamt;
            FN_SLT:   aluOut = `EXU_XLEN'($signed(dec.opA) < $signed(dec.opB));
            FN_SLTU:  aluOut = `EXU_XLEN'(dec.opA < dec.opB);
            FN_XOR:   aluOut = dec.opA ^ dec.opB;
            FN_SRL:   aluOut = dec.opA >> shamt;
            FN_SRA:   aluOut = $signed(dec.opA) >>> shamt;
            FN_OR:    aluOut = dec.opA | dec.opB;
            FN_AND:   aluOut = dec.opA & dec.opB;
            FN_PASSB: aluOut = dec.opB;
            default:  aluOut = '0;
        endcase
    end

    always_comb begin
        case (dec.cond)
            BR_EQ:     taken = dec.rs1 == dec.rs2;
            BR_NE:     taken = dec.rs1 != dec.rs2;
            BR_LT:     taken = $signed(dec.rs1) < $signed(dec.rs2);
            BR_GE:     taken = $signed(dec.rs1) >= $signed(dec.rs2);
            BR_LTU:    taken = dec.rs1 < dec.rs2;
            BR_GEU:    taken = dec.rs1 >= dec.rs2;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // unconditional jump based on rs1 is JALR
    assign isJalr = (dec.cond == BR_ALWAYS) && (dec.targetBase == `EXU_ALEN'(dec.rs1));

    always_comb begin
        target = dec.targetBase + `EXU_ALEN'(dec.imm);
        if (isJalr) begin
            target[0] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else if (rdy) begin
            ex.valid    <= dec.valid;
            ex.nick     <= dec.nick;
            ex.data     <= aluOut;
            ex.writesRd <= dec.writesRd;
            ex.jump     <= taken;
            ex.jumpPc   <= taken ? target : '0; // no stale target on fall-through
        end
    end

endmodule

`default_nettype wire

//--- exuDecode.sv
`default_nettype none
`include "exu_consts.svh"

module exuDecode import exuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  rsIssue_t issue,
    output decoded_t dec
);

    opASel_e              aSel;
    opBSel_e              bSel;
    aluFn_e               fn;
    brCond_e              cond;
    logic                 writesRd;
    logic [`EXU_XLEN-1:0] opA;
    logic [`EXU_XLEN-1:0] opB;

    always_comb begin
        aSel = A_RS1;
        fn   = FN_ADD;
        cond = BR_NONE;
        bSel = (issue.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                 OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND}) ? B_RS2 : B_IMM;
        case (issue.op)
            OP_LUI: begin
                aSel = A_ZERO;
                fn   = FN_PASSB; // imm already shifted up
            end
            OP_AUIPC: aSel = A_PC;
            OP_JAL, OP_JALR: begin
                aSel = A_PC; // link value pc + 4
                bSel = B_LINK;
                cond = BR_ALWAYS;
            end
            OP_BEQ:  cond = BR_EQ;
            OP_BNE:  cond = BR_NE;
            OP_BLT:  cond = BR_LT;
            OP_BGE:  cond = BR_GE;
            OP_BLTU: cond = BR_LTU;
            OP_BGEU: cond = BR_GEU;
            OP_SUB:            fn = FN_SUB;
            OP_SLL, OP_SLLI:   fn = FN_SLL;
            OP_SLT, OP_SLTI:   fn = FN_SLT;
            OP_SLTU, OP_SLTIU: fn = FN_SLTU;
            OP_XOR, OP_XORI:   fn = FN_XOR;
            OP_SRL, OP_SRLI:   fn = FN_SRL;
            OP_SRA, OP_SRAI:   fn = FN_SRA;
            OP_OR, OP_ORI:     fn = FN_OR;
            OP_AND, OP_ANDI:   fn = FN_AND;
            default:           fn = FN_ADD;
        endcase
        writesRd = cond inside {BR_NONE, BR_ALWAYS}; // branches write nothing
    end

    always_comb begin
        case (aSel)
            A_PC:    opA = `EXU_XLEN'(issue.pc);
            A_ZERO:  opA = '0;
            default: opA = issue.rs1;
        endcase
        case (bSel)
            B_RS2:   opB = issue.rs2;
            B_LINK:  opB = `EXU_XLEN'(`EXU_LINK_STEP);
            default: opB = issue.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else if (rdy) begin
            dec.valid    <= issue.en;
            dec.nick     <= issue.nick;
            dec.opA      <= opA;
            dec.opB      <= opB;
            dec.fn       <= fn;
            dec.cond     <= cond;
            dec.rs2      <= issue.rs2;
            dec.imm      <= issue.imm;
            dec.writesRd <= writesRd;
            dec.targetBase <= (issue.op == OP_JALR) ? `EXU_ALEN'(issue.rs1) : issue.pc;
            // JAL has no compare, so rs1 is set apart from the pc base
            dec.rs1 <= (issue.op == OP_JAL) ? `EXU_XLEN'(~issue.pc) : issue.rs1;
        end
    end

endmodule

`default_nettype wire

//--- exuPkg.sv
`default_nettype none
`include "exu_consts.svh"

package exuPkg;

    typedef enum logic [4:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } aluOp_e;

    typedef enum logic [3:0] {
        FN_ADD, FN_SUB, FN_SLL, FN_SLT, FN_SLTU, FN_XOR,
        FN_SRL, FN_SRA, FN_OR, FN_AND, FN_PASSB
    } aluFn_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } brCond_e;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} opASel_e;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_LINK} opBSel_e;

    typedef struct packed {
        logic                   en;
        logic [`EXU_ALEN-1:0]   pc;
        aluOp_e                 op;
        logic [`EXU_XLEN-1:0]   imm;
        logic [`EXU_NICK_W-1:0] nick;
        logic [`EXU_XLEN-1:0]   rs1;
        logic [`EXU_XLEN-1:0]   rs2;
    } rsIssue_t;

    typedef struct packed {
        logic                   valid;
        logic [`EXU_NICK_W-1:0] nick;
        logic [`EXU_XLEN-1:0]   opA;
        logic [`EXU_XLEN-1:0]   opB;
        aluFn_e                 fn;
        brCond_e                cond;
        logic [`EXU_XLEN-1:0]   rs1; // compare operands
        logic [`EXU_XLEN-1:0]   rs2;
        logic [`EXU_ALEN-1:0]   targetBase;
        logic [`EXU_XLEN-1:0]   imm;
        logic                   writesRd;
    } decoded_t;

    typedef struct packed {
        logic                   valid;
        logic [`EXU_NICK_W-1:0] nick;
        logic [`EXU_XLEN-1:0]   data;
        logic                   writesRd;
        logic                   jump;
        logic [`EXU_ALEN-1:0]   jumpPc;
    } executed_t;

    typedef struct packed {
        logic                   en;
        logic [`EXU_NICK_W-1:0] nick;
        logic [`EXU_XLEN-1:0]   data;
    } cdbResult_t;

    typedef struct packed {
        logic                   en;
        logic [`EXU_NICK_W-1:0] nick;
        logic [`EXU_XLEN-1:0]   data;
        logic                   jump;
        logic [`EXU_ALEN-1:0]   jumpPc;
    } robResult_t;

endpackage

`default_nettype wire

//--- exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data path width
`define EXU_XLEN 32

// pc and jump target width
`define EXU_ALEN 32

// rob tag width
`define EXU_NICK_W 4

// rv32 shifts use five bits
`define EXU_SHAMT_W 5

// return address is pc plus one instruction
`define EXU_LINK_STEP 4

`endif
